/* tb.f */
+incdir+design
design/frame_ctrl_pkg.sv
design/frame_io_pkg.sv
design/frame_cfg_if.sv
design/frame_cfg_regs.sv
design/frame_reset.sv
design/frame_joy_map.sv
design/frame_board.sv
design/frame_mist.sv
bench/tb_frame.sv

/* Makefile */
TOP := tb_frame

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f tb.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* bench/tb_frame.sv */
// ==============================
// Board frame testbench
// APB tasks, reference models,
// compare tasks and the checker
// ==============================

`timescale 1ns/1ps
`include "frame_defs.svh"

module tb_frame
    import frame_ctrl_pkg::*;
    import frame_io_pkg::*;
();

    localparam int WAIT_LIMIT = 64;

    logic                   clk_sys = 1'b0;
    logic                   rst_n;
    logic                   pll_locked;
    logic [31:0]            paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    status_t                status;
    logic                   rst;
    logic                   game_rst;
    logic                   game_rst_n;
    joy_set_t               board_joystick;
    game_set_t              game_joystick;
    logic [NUM_PLAYERS-1:0] game_coin;
    logic [NUM_PLAYERS-1:0] game_start;
    logic                   game_service;
    logic                   enable_fm;
    logic                   enable_psg;
    logic                   dip_test;
    logic                   dip_pause;
    logic                   dip_flip;
    logic [1:0]             dip_fxlevel;
    logic [3:0]             gfx_en;
    logic                   led;
    dips_t                  dips_got;

    // Reference state, updated on the edge that ends each write
    status_t    status_ref;
    core_mod_t  core_mod_ref;
    game_set_t  exp_joy;
    logic [3:0] exp_coin;
    logic [3:0] exp_start;
    logic       exp_svc;
    game_set_t  rel_joy;
    logic [3:0] rel_coin;
    logic [3:0] rel_start;
    logic       rel_svc;
    logic       joy_chk_en = 1'b0;
    logic       timed_out = 1'b0;
    integer     seed = 32'h9614;
    int         checks = 0;
    int         errors = 0;
    int         cycles;
    logic [31:0] rd;
    logic        err;

    always #50 clk_sys = ~clk_sys;

    frame_mist dut0 (
        .clk_sys        ( clk_sys        ),
        .rst_n          ( rst_n          ),
        .pll_locked     ( pll_locked     ),
        .paddr          ( paddr          ),
        .psel           ( psel           ),
        .penable        ( penable        ),
        .pwrite         ( pwrite         ),
        .pwdata         ( pwdata         ),
        .prdata         ( prdata         ),
        .pready         ( pready         ),
        .pslverr        ( pslverr        ),
        .status         ( status         ),
        .rst            ( rst            ),
        .game_rst       ( game_rst       ),
        .game_rst_n     ( game_rst_n     ),
        .board_joystick ( board_joystick ),
        .game_joystick  ( game_joystick  ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_service   ( game_service   ),
        .enable_fm      ( enable_fm      ),
        .enable_psg     ( enable_psg     ),
        .dip_test       ( dip_test       ),
        .dip_pause      ( dip_pause      ),
        .dip_flip       ( dip_flip       ),
        .dip_fxlevel    ( dip_fxlevel    ),
        .gfx_en         ( gfx_en         ),
        .led            ( led            )
    );

    assign dips_got = {enable_fm, enable_psg, dip_test, dip_pause, dip_flip, dip_fxlevel};

    // Game side view of the board words, one quarter turn when rotated
    function automatic void map_joy(input joy_set_t b, input logic rot,
                                    output game_set_t g, output logic [3:0] coin,
                                    output logic [3:0] start, output logic svc);
        logic [3:0] dir;
        logic [5:0] btn;
        logic       inv;
        inv = 1'(`FRAME_INPUTS_ACTIVE_LOW);
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            dir = rot ? {b[p][1], b[p][0], b[p][2], b[p][3]} : b[p][3:0];
            btn = b[p][9:4];
            for (int k = `FRAME_BUTTONS; k < 6; k++) begin
                btn[k] = 1'b0;
            end
            g[p]     = {btn, dir} ^ {10{inv}};
            coin[p]  = b[p][10] ^ inv;
            start[p] = b[p][11] ^ inv;
        end
        svc = b[0][12] ^ inv;
    endfunction

    function automatic dips_t decode_dips(input status_t s);
        dips_t d;
        d.enable_fm   = ~s[1];
        d.enable_psg  = ~s[2];
        d.dip_test    = s[5];
        d.dip_pause   = s[6];
        d.dip_flip    = s[7];
        d.dip_fxlevel = s[9:8];
        return d;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_dips(input dips_t got, input dips_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_joy(input game_set_t got, input game_set_t exp,
                             input logic [8:0] got_ctl, input logic [8:0] exp_ctl,
                             input string what);
        checks++;
        if (got !== exp || got_ctl !== exp_ctl) begin
            errors++;
            $display("ERR %0t: %s got %h/%h expected %h/%h", $time, what,
                     got, got_ctl, exp, exp_ctl);
        end
    endtask

    // Main flow parks here, the watchdog below ends the run
    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        timed_out = 1'b1;
        forever @(posedge clk_sys);
    endtask

    always @(posedge timed_out) begin
        $display("%0d checks, %0d errors", checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic drive_random_joy();
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            board_joystick[p] <= 16'($random(seed));
        end
    endtask

    // Setup phase, access phase, then sample in the access phase
    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int waited;
        @(posedge clk_sys);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_sys);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk_sys);
        while (!pready && waited < WAIT_LIMIT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (!pready) begin
            stop_on_timeout("APB pready");
        end else begin
            check_word(waited, 32'd0, "APB wait states");
            rdata  = prdata;
            slverr = pslverr;
            @(posedge clk_sys);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] ignored;
        apb_access(1'b1, addr, data, ignored, slverr);
        case (addr)
            `FRAME_REG_STATUS_LO: status_ref[31:0]  <= data;
            `FRAME_REG_STATUS_HI: status_ref[63:32] <= data;
            `FRAME_REG_CORE_MOD:  core_mod_ref      <= data[6:0];
            default: ;
        endcase
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_access(1'b0, addr, 32'd0, data, slverr);
    endtask

    task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] data;
        logic        slverr;
        apb_read(addr, data, slverr);
        check_word(data, exp, what);
        check_bit(slverr, 1'b0, {what, " pslverr"});
    endtask

    task automatic compare_regs(input string what);
        expect_read(`FRAME_REG_STATUS_LO, status_ref[31:0], {what, " STATUS_LO"});
        expect_read(`FRAME_REG_STATUS_HI, status_ref[63:32], {what, " STATUS_HI"});
        expect_read(`FRAME_REG_CORE_MOD, {25'd0, core_mod_ref}, {what, " CORE_MOD"});
        expect_read(`FRAME_REG_ID, `FRAME_ID, {what, " ID"});
    endtask

    // Wait for rst or game_rst to drop
    task automatic wait_release(input logic game_side);
        int waited;
        waited = 0;
        @(negedge clk_sys);
        while ((game_side ? game_rst : rst) && waited < WAIT_LIMIT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (game_side ? game_rst : rst) begin
            stop_on_timeout(game_side ? "game reset release" : "frame reset release");
        end
    endtask

    task automatic measure_game_rst(input string what);
        int held;
        held = 0;
        @(negedge clk_sys);
        while (game_rst && held < WAIT_LIMIT) begin
            check_bit(game_rst_n, 1'b0, "game_rst_n while held");
            held++;
            @(negedge clk_sys);
        end
        if (game_rst) begin
            stop_on_timeout(what);
        end else begin
            check_bit(game_rst_n, 1'b1, "game_rst_n after release");
            check_word(held, `FRAME_GAME_RST_CYCLES, what);
        end
    endtask

    // Expected outputs from the values the DUT samples on this edge
    always @(posedge clk_sys) begin
        map_joy(board_joystick, (status_ref[4:3] == 2'b00) && core_mod_ref[0],
                exp_joy, exp_coin, exp_start, exp_svc);
    end

    always @(negedge clk_sys) begin
        if (joy_chk_en) begin
            check_joy(game_joystick, exp_joy, {game_coin, game_start, game_service},
                      {exp_coin, exp_start, exp_svc}, "joystick map");
        end
    end

    initial begin
        rst_n          <= 1'b0;
        pll_locked     <= 1'b0;
        paddr          <= '0;
        psel           <= 1'b0;
        penable        <= 1'b0;
        pwrite         <= 1'b0;
        pwdata         <= '0;
        board_joystick <= '0;
        gfx_en         <= 4'hF;
        status_ref     <= '0;
        core_mod_ref   <= '0;
        map_joy('0, 1'b0, rel_joy, rel_coin, rel_start, rel_svc);
        repeat (16) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        check_bit(pslverr, 1'b0, "pslverr after reset");
        check_bit(led, 1'b0, "LED after reset");
        check_bit(rst, 1'b1, "rst before PLL lock");

        // Frame reset, outputs stay released while it holds
        @(posedge clk_sys);
        pll_locked <= 1'b1;
        cycles = 0;
        @(negedge clk_sys);
        while (rst && cycles < WAIT_LIMIT) begin
            check_joy(game_joystick, rel_joy, {game_coin, game_start, game_service},
                      {rel_coin, rel_start, rel_svc}, "released in frame reset");
            @(posedge clk_sys);
            drive_random_joy();
            cycles++;
            @(negedge clk_sys);
        end
        if (rst) begin
            stop_on_timeout("frame reset release");
        end else begin
            // Hold counted from the raised lock
            check_word(cycles, `FRAME_RST_CYCLES, "frame reset hold");
        end

        // Register access
        expect_read(`FRAME_REG_CTRL, 32'd0, "CTRL reset value");
        compare_regs("reset value");
        apb_write(`FRAME_REG_STATUS_LO, 32'h5A5A_3C3E, err);
        apb_write(`FRAME_REG_STATUS_HI, 32'hC3A5_0F96, err);
        apb_write(`FRAME_REG_CORE_MOD, 32'h0000_00D5, err);
        apb_write(`FRAME_REG_ID, 32'd0, err);
        compare_regs("write");
        apb_write(32'h0000_0014, 32'hFFFF_FFFF, err);
        check_bit(err, 1'b1, "pslverr on unmapped write");
        apb_read(32'h0000_0014, rd, err);
        check_bit(err, 1'b1, "pslverr on unmapped read");
        check_word(rd, 32'd0, "unmapped read data");
        compare_regs("unmapped write");
        expect_read(`FRAME_REG_CTRL, 32'd0, "CTRL after unmapped write");

        // DIP decode from random option words
        for (int i = 0; i < 8; i++) begin
            apb_write(`FRAME_REG_STATUS_LO, 32'($random(seed)) & 32'hFFFF_FFFE, err);
            @(negedge clk_sys);
            check_dips(dips_got, decode_dips(status_ref), "DIP decode");
            check_word(status[31:0], status_ref[31:0], "status output");
            check_word(status[63:32], status_ref[63:32], "status output high");
        end

        // Joystick map, unrotated then rotated
        apb_write(`FRAME_REG_STATUS_LO, 32'd0, err);
        apb_write(`FRAME_REG_CORE_MOD, 32'd0, err);
        joy_chk_en = 1'b1;
        for (int i = 0; i < 200; i++) begin
            @(posedge clk_sys);
            drive_random_joy();
        end
        apb_write(`FRAME_REG_CORE_MOD, 32'd1, err);
        for (int i = 0; i < 200; i++) begin
            @(posedge clk_sys);
            drive_random_joy();
        end
        @(posedge clk_sys);
        @(posedge clk_sys);
        joy_chk_en = 1'b0;

        // Game reset causes
        wait_release(1'b1);
        apb_write(`FRAME_REG_CTRL, 32'd1, err);
        measure_game_rst("game reset after rst_req");
        apb_write(`FRAME_REG_STATUS_LO, status_ref[31:0] ^ 32'h0000_0080, err);
        measure_game_rst("game reset after dip_flip change");
        apb_write(`FRAME_REG_CTRL, 32'd2, err);
        @(negedge clk_sys);
        check_bit(game_rst, 1'b1, "game_rst during download");
        check_bit(led, 1'b0, "LED during download");
        expect_read(`FRAME_REG_CTRL, 32'd2, "CTRL downloading");
        apb_write(`FRAME_REG_CTRL, 32'd0, err);
        measure_game_rst("game reset after download");

        // LED conditions one at a time
        check_bit(led, 1'b1, "LED when idle");
        for (int b = 0; b < 4; b++) begin
            @(posedge clk_sys);
            gfx_en <= 4'hF & ~(4'b0001 << b);
            @(negedge clk_sys);
            check_bit(led, 1'b0, "LED with a gfx_en bit clear");
        end
        @(posedge clk_sys);
        gfx_en <= 4'hF;
        @(negedge clk_sys);
        check_bit(led, 1'b1, "LED with gfx_en restored");
        @(posedge clk_sys);
        pll_locked <= 1'b0;
        @(negedge clk_sys);
        check_bit(rst, 1'b1, "rst on PLL loss");
        check_bit(led, 1'b0, "LED on PLL loss");
        @(posedge clk_sys);
        pll_locked <= 1'b1;
        wait_release(1'b0);
        check_bit(led, 1'b1, "LED after relock");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* design/frame_mist.sv */
// ==============================
// Board frame top level
// APB register access and board I/O
// ==============================

`timescale 1ns/1ps

module frame_mist
    import frame_ctrl_pkg::*;
    import frame_io_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   pll_locked,
    // APB slave
    input  logic [31:0]            paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output status_t                status,
    // Resets
    output logic                   rst,
    output logic                   game_rst,
    output logic                   game_rst_n,
    // Joysticks
    input  joy_set_t               board_joystick,
    output game_set_t              game_joystick,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_service,
    // DIP settings
    output logic                   enable_fm,
    output logic                   enable_psg,
    output logic                   dip_test,
    output logic                   dip_pause,
    output logic                   dip_flip,
    output logic [1:0]             dip_fxlevel,
    // Debug
    input  logic [3:0]             gfx_en,
    output logic                   led
);

    dips_t dips;

    frame_cfg_if u_cfg_if ();

    frame_cfg_regs u_base (
        .clk_sys ( clk_sys  ),
        .rst_n   ( rst_n    ),
        .paddr   ( paddr    ),
        .psel    ( psel     ),
        .penable ( penable  ),
        .pwrite  ( pwrite   ),
        .pwdata  ( pwdata   ),
        .prdata  ( prdata   ),
        .pready  ( pready   ),
        .pslverr ( pslverr  ),
        .cfg     ( u_cfg_if )
    );

    frame_board u_board (
        .clk_sys        ( clk_sys        ),
        .rst_n          ( rst_n          ),
        .pll_locked     ( pll_locked     ),
        .gfx_en         ( gfx_en         ),
        .board_joystick ( board_joystick ),
        .cfg            ( u_cfg_if       ),
        .rst            ( rst            ),
        .game_rst       ( game_rst       ),
        .game_rst_n     ( game_rst_n     ),
        .game_joystick  ( game_joystick  ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_service   ( game_service   ),
        .dips           ( dips           ),
        .led            ( led            )
    );

    assign status      = u_cfg_if.status;
    assign enable_fm   = dips.enable_fm;
    assign enable_psg  = dips.enable_psg;
    assign dip_test    = dips.dip_test;
    assign dip_pause   = dips.dip_pause;
    assign dip_flip    = dips.dip_flip;
    assign dip_fxlevel = dips.dip_fxlevel;

endmodule

/* design/frame_board.sv */
// ==============================
// Board block
// DIP decode, status LED, resets
// and joystick mapping
// ==============================

`timescale 1ns/1ps

module frame_board
    import frame_ctrl_pkg::*;
    import frame_io_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   pll_locked,
    input  logic [3:0]             gfx_en,
    input  joy_set_t               board_joystick,
    frame_cfg_if.board             cfg,
    output logic                   rst,
    output logic                   game_rst,
    output logic                   game_rst_n,
    output game_set_t              game_joystick,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_service,
    output dips_t                  dips,
    output logic                   led
);

    logic rotate;

    // Sound enables are stored inverted
    always_comb begin
        dips.enable_fm   = ~cfg.status[STS_FM_N];
        dips.enable_psg  = ~cfg.status[STS_PSG_N];
        dips.dip_test    = cfg.status[STS_TEST];
        dips.dip_pause   = cfg.status[STS_PAUSE];
        dips.dip_flip    = cfg.status[STS_FLIP];
        dips.dip_fxlevel = cfg.status[STS_FX_LSB +: 2];
    end

    // Vertical game shown on an unrotated screen
    assign rotate = (cfg.status[STS_ROT_LSB +: 2] == 2'b00) & cfg.core_mod[0];

    assign led = ~(cfg.ctrl.downloading | rst | ~pll_locked | ~&gfx_en);

    frame_reset u_reset (
        .clk_sys     ( clk_sys              ),
        .rst_n       ( rst_n                ),
        .pll_locked  ( pll_locked           ),
        .downloading ( cfg.ctrl.downloading ),
        .rst_req     ( cfg.ctrl.rst_req     ),
        .dip_flip    ( dips.dip_flip        ),
        .rst         ( rst                  ),
        .game_rst    ( game_rst             )
    );

    assign game_rst_n = ~game_rst;

    frame_joy_map u_joy (
        .clk_sys        ( clk_sys        ),
        .rst_n          ( rst_n          ),
        .rst            ( rst            ),
        .rotate         ( rotate         ),
        .board_joystick ( board_joystick ),
        .game_joystick  ( game_joystick  ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_service   ( game_service   )
    );

endmodule

/* design/frame_joy_map.sv */
// ==============================
// Joystick mapper
// Rotation, button mask, polarity
// ==============================

`timescale 1ns/1ps
`include "frame_defs.svh"

module frame_joy_map
    import frame_io_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   rst,
    input  logic                   rotate,
    input  joy_set_t               board_joystick,
    output game_set_t              game_joystick,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_service
);

    localparam int         BUTTONS  = `FRAME_BUTTONS;
    localparam logic [5:0] BTN_MASK = 6'((1 << BUTTONS) - 1);
    localparam logic       INV      = 1'(`FRAME_INPUTS_ACTIVE_LOW);

    game_set_t              joy_nxt;
    game_set_t              joy_q;
    logic [NUM_PLAYERS-1:0] coin_q;
    logic [NUM_PLAYERS-1:0] start_q;
    logic                   service_q;

    // Quarter turn for vertical screens
    function automatic logic [3:0] map_dir(input board_joy_t j, input logic rot);
        logic [3:0] d;
        d[JOY_RIGHT] = rot ? j[JOY_UP]    : j[JOY_RIGHT];
        d[JOY_DOWN]  = rot ? j[JOY_RIGHT] : j[JOY_DOWN];
        d[JOY_LEFT]  = rot ? j[JOY_DOWN]  : j[JOY_LEFT];
        d[JOY_UP]    = rot ? j[JOY_LEFT]  : j[JOY_UP];
        return d;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            joy_nxt[p] = {board_joystick[p][JOY_BTN +: 6] & BTN_MASK,
                          map_dir(board_joystick[p], rotate)};
        end
    end

    // Held released during frame reset
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            joy_q     <= '0;
            coin_q    <= '0;
            start_q   <= '0;
            service_q <= 1'b0;
        end else if (rst) begin
            joy_q     <= '0;
            coin_q    <= '0;
            start_q   <= '0;
            service_q <= 1'b0;
        end else begin
            joy_q <= joy_nxt;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                coin_q[p]  <= board_joystick[p][JOY_COIN];
                start_q[p] <= board_joystick[p][JOY_START];
            end
            service_q <= board_joystick[0][JOY_SERVICE];
        end
    end

    assign game_joystick = joy_q ^ {$bits(game_set_t){INV}};
    assign game_coin     = coin_q ^ {NUM_PLAYERS{INV}};
    assign game_start    = start_q ^ {NUM_PLAYERS{INV}};
    assign game_service  = service_q ^ INV;

endmodule

/* design/frame_reset.sv */
// ==============================
// Reset sequencer
// Frame reset after PLL lock and
// the stretched game reset
// ==============================

`timescale 1ns/1ps
`include "frame_defs.svh"

module frame_reset (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic downloading,
    input  logic rst_req,
    input  logic dip_flip,
    output logic rst,
    output logic game_rst
);

    localparam int RST_CYCLES  = `FRAME_RST_CYCLES;
    localparam int GAME_CYCLES = `FRAME_GAME_RST_CYCLES;
    localparam int RST_W       = $clog2(RST_CYCLES + 1);
    localparam int GAME_W      = $clog2(GAME_CYCLES + 1);

    logic [RST_W-1:0]  rst_cnt;
    logic              rst_hold;
    logic [GAME_W-1:0] game_cnt;
    logic              flip_q;
    logic              dl_q;
    logic              cause;

    // Frame reset counts lock cycles, restarts when lock drops
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rst_cnt  <= '0;
            rst_hold <= 1'b1;
        end else if (!pll_locked) begin
            rst_cnt  <= '0;
            rst_hold <= 1'b1;
        end else if (rst_hold) begin
            if (rst_cnt == RST_W'(RST_CYCLES - 1)) begin
                rst_hold <= 1'b0;
            end else begin
                rst_cnt <= rst_cnt + 1'b1;
            end
        end
    end

    assign rst = rst_hold | ~pll_locked;

    // Request pulse, flip change or falling download
    assign cause = rst_req | (dip_flip ^ flip_q) | (dl_q & ~downloading);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            flip_q   <= 1'b0;
            dl_q     <= 1'b0;
            game_cnt <= '0;
        end else begin
            flip_q <= dip_flip;
            dl_q   <= downloading;
            // Cause cycle is the first held cycle
            if (cause) begin
                game_cnt <= GAME_W'(GAME_CYCLES - 1);
            end else if (game_cnt != '0) begin
                game_cnt <= game_cnt - 1'b1;
            end
        end
    end

    assign game_rst = rst | downloading | cause | (game_cnt != '0);

endmodule

/* design/frame_cfg_regs.sv */
// ==============================
// APB register block
// Option word, core mode, control
// and the identity register
// ==============================

`timescale 1ns/1ps
`include "frame_defs.svh"

module frame_cfg_regs
    import frame_ctrl_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    frame_cfg_if.regs   cfg
);

    status_t     status_q;
    core_mod_t   core_mod_q;
    ctrl_t       ctrl_q;
    logic        access;
    logic        wr_en;
    logic        wr_lo;
    logic        wr_hi;
    logic        wr_mod;
    logic        wr_ctrl;
    logic        mapped;
    logic [31:0] rd_data;

    // Access phase of an APB transfer
    assign access  = psel & penable;
    assign wr_en   = access & pwrite;
    assign wr_lo   = wr_en && (paddr == `FRAME_REG_STATUS_LO);
    assign wr_hi   = wr_en && (paddr == `FRAME_REG_STATUS_HI);
    assign wr_mod  = wr_en && (paddr == `FRAME_REG_CORE_MOD);
    assign wr_ctrl = wr_en && (paddr == `FRAME_REG_CTRL);

    // Read mux and map check
    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (paddr)
            `FRAME_REG_STATUS_LO: rd_data = status_q[31:0];
            `FRAME_REG_STATUS_HI: rd_data = status_q[63:32];
            `FRAME_REG_CORE_MOD:  rd_data = {25'd0, core_mod_q};
            `FRAME_REG_CTRL:      rd_data = {30'd0, ctrl_q.downloading, 1'b0};
            `FRAME_REG_ID:        rd_data = `FRAME_ID;
            default:              mapped  = 1'b0;
        endcase
    end

    assign prdata  = rd_data;
    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            status_q   <= '0;
            core_mod_q <= '0;
            ctrl_q     <= '0;
        end else begin
            // Menu reset bit only lives for one cycle
            if (wr_lo) begin
                status_q[31:0] <= pwdata;
            end else begin
                status_q[STS_RESET] <= 1'b0;
            end
            if (wr_hi) begin
                status_q[63:32] <= pwdata;
            end
            if (wr_mod) begin
                core_mod_q <= pwdata[$bits(core_mod_t)-1:0];
            end
            if (wr_ctrl) begin
                ctrl_q.downloading <= pwdata[1];
            end
            // Either source gives a single pulse
            ctrl_q.rst_req <= (wr_lo & pwdata[STS_RESET]) | (wr_ctrl & pwdata[0]);
        end
    end

    assign cfg.status   = status_q;
    assign cfg.core_mod = core_mod_q;
    assign cfg.ctrl     = ctrl_q;

endmodule

/* design/frame_cfg_if.sv */
// ==============================
// Configuration bundle from the
// register block to the board
// ==============================

`timescale 1ns/1ps

interface frame_cfg_if
    import frame_ctrl_pkg::*;
();

    status_t   status;
    core_mod_t core_mod;
    ctrl_t     ctrl;

    modport regs  (output status, output core_mod, output ctrl);
    modport board (input  status, input  core_mod, input  ctrl);

endinterface

/* design/frame_io_pkg.sv */
// ==============================
// Joystick and game input types
// ==============================

package frame_io_pkg;

    localparam int NUM_PLAYERS = 4;

    // Board joystick word layout, active high
    localparam int JOY_RIGHT   = 0;
    localparam int JOY_LEFT    = 1;
    localparam int JOY_DOWN    = 2;
    localparam int JOY_UP      = 3;
    localparam int JOY_BTN     = 4;
    localparam int JOY_COIN    = 10;
    localparam int JOY_START   = 11;
    localparam int JOY_SERVICE = 12;

    typedef logic [15:0] board_joy_t;

    // Directions plus six buttons
    typedef logic [9:0] game_joy_t;

    // Index 0 is player 1
    typedef board_joy_t [NUM_PLAYERS-1:0] joy_set_t;
    typedef game_joy_t  [NUM_PLAYERS-1:0] game_set_t;

endpackage

/* design/frame_ctrl_pkg.sv */
// ==============================
// Configuration and status types
// Option word, core mode, control
// bits and decoded DIP settings
// ==============================

package frame_ctrl_pkg;

    // Bit positions inside the option word
    localparam int STS_RESET   = 0;
    localparam int STS_FM_N    = 1;
    localparam int STS_PSG_N   = 2;
    localparam int STS_ROT_LSB = 3;
    localparam int STS_TEST    = 5;
    localparam int STS_PAUSE   = 6;
    localparam int STS_FLIP    = 7;
    localparam int STS_FX_LSB  = 8;

    typedef logic [63:0] status_t;

    // Bit 0 set for vertical games
    typedef logic [6:0] core_mod_t;

    typedef struct packed {
        logic downloading;
        logic rst_req;
    } ctrl_t;

    typedef struct packed {
        logic       enable_fm;
        logic       enable_psg;
        logic       dip_test;
        logic       dip_pause;
        logic       dip_flip;
        logic [1:0] dip_fxlevel;
    } dips_t;

endpackage

/* design/frame_defs.svh */
// ==============================
// Board frame build constants
// Register map, reset hold counts,
// button count and input polarity
// ==============================

`ifndef FRAME_DEFS_SVH
`define FRAME_DEFS_SVH

// APB byte offsets
`define FRAME_REG_STATUS_LO     32'h0000_0000
`define FRAME_REG_STATUS_HI     32'h0000_0004
`define FRAME_REG_CORE_MOD      32'h0000_0008
`define FRAME_REG_CTRL          32'h0000_000C
`define FRAME_REG_ID            32'h0000_0010

// Read-only identity word
`define FRAME_ID                32'h4652_4D31

// Cycles of reset hold
`define FRAME_RST_CYCLES        16
`define FRAME_GAME_RST_CYCLES   8

// Buttons in use per player, 1 to 6
`define FRAME_BUTTONS           2
`define FRAME_INPUTS_ACTIVE_LOW 1

`endif
